// File: verilog/calc_pkg.sv
package calc_pkg;

    localparam int WORD_W    = 16;                 // Operand and result width
    localparam int DIGIT_W   = 4;                  // Keypad code width
    localparam int ADD_STEPS = 4;                  // One nibble per step
    localparam int MUL_STEPS = 16;                 // One multiplier bit per step
    localparam int STEP_W    = 5;                  // Holds MUL_STEPS - 1 and more

    localparam logic [DIGIT_W-1:0] DIGIT_MAX = 4'd9;   // Largest decimal key

    // One-hot operator keys
    localparam logic [2:0] OP_ADD = 3'b001;        // Addition
    localparam logic [2:0] OP_SUB = 3'b010;        // Subtraction, wraps
    localparam logic [2:0] OP_MUL = 3'b100;        // Multiply, low half kept

    typedef enum logic [2:0] {
        GET_FIRST   = 3'b000,                      // Entering first operand
        GET_SECOND  = 3'b001,                      // Entering second operand
        LAUNCH      = 3'b010,                      // Start pulse to the units
        EXECUTE     = 3'b011,                      // Units stepping
        SHOW_RESULT = 3'b100                       // Result out, complete high
    } calc_state_t;

endpackage

// File: verilog/exec_if.sv
`timescale 1ns/1ps

interface exec_if
    import calc_pkg::*;
();

    logic [WORD_W-1:0] operand_a;                  // From first accumulator
    logic [WORD_W-1:0] operand_b;                  // From second accumulator
    logic              sub;                        // Adder runs as subtractor
    logic              start;                      // One-cycle launch pulse
    logic [STEP_W-1:0] step_len;                   // Steps of this operation
    logic [STEP_W-1:0] step_idx;                   // Counts down to zero
    logic              last;                       // Final step in progress
    logic [WORD_W-1:0] sum_result;                 // Adder/subtractor output
    logic [WORD_W-1:0] mul_result;                 // Multiplier output

    modport ctrl (
        output sub, start, step_len,
        input  last, sum_result, mul_result
    );

    modport counter (
        input  start, step_len,
        output step_idx, last
    );

    modport adder (
        input  operand_a, operand_b, sub, start, step_idx,
        output sum_result
    );

    modport mult (
        input  operand_a, operand_b, start,
        output mul_result
    );

endinterface

// File: verilog/calc_control.sv
`timescale 1ns/1ps

module calc_control
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  logic               read_input,      // Keystroke strobe
    input  logic [DIGIT_W-1:0] keypad_input,    // Key code of the strobe
    input  logic [2:0]         operator_input,  // One-hot operator level
    input  logic               equal_input,     // Equal key strobe
    output logic               load_a,          // Keystroke into first operand
    output logic               load_b,          // Keystroke into second operand
    output logic               clear_ops,       // Zero both operands
    exec_if.ctrl               exec,
    output logic               complete,        // One-cycle done pulse
    output logic [WORD_W-1:0]  display_output   // Held result
);

    calc_state_t       state;                   // Current FSM state
    calc_state_t       next_state;
    logic [2:0]        op_q;                    // Latched operator
    logic              op_valid;                // Operator key is one-hot
    logic              settle_q;                // Cycle after last
    logic [WORD_W-1:0] result_sel;              // Unit output for op_q

    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    // Raw keystroke routing, digit range checked in the accumulator
    assign load_a = read_input && (state == GET_FIRST);
    assign load_b = read_input && (state == GET_SECOND);

    assign clear_ops = (state == SHOW_RESULT);  // Next entry starts from zero
    assign complete  = (state == SHOW_RESULT);  // Single-cycle state

    assign exec.start    = (state == LAUNCH);
    assign exec.sub      = (op_q == OP_SUB);
    assign exec.step_len = (op_q == OP_MUL) ? STEP_W'(MUL_STEPS) : STEP_W'(ADD_STEPS);

    assign result_sel = (op_q == OP_MUL) ? exec.mul_result : exec.sum_result;

    always_comb begin
        next_state = state;                     // Hold by default
        case (state)
            GET_FIRST: begin
                if (op_valid) begin
                    next_state = GET_SECOND;    // Operator ends first operand
                end
            end
            GET_SECOND: begin
                if (equal_input) begin
                    next_state = LAUNCH;
                end
            end
            LAUNCH: begin
                next_state = EXECUTE;           // Start goes out for one cycle
            end
            EXECUTE: begin
                if (settle_q) begin
                    next_state = SHOW_RESULT;   // Last nibble written by now
                end
            end
            SHOW_RESULT: begin
                next_state = GET_FIRST;
            end
            default: begin
                next_state = GET_FIRST;         // Unused encodings recover
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= GET_FIRST;
            op_q           <= '0;
            settle_q       <= 1'b0;
            display_output <= '0;
        end else begin
            state    <= next_state;
            settle_q <= (state == EXECUTE) && exec.last;    // Wait one cycle
            if ((state == GET_FIRST) && op_valid) begin
                op_q <= operator_input;         // Keep until the next entry
            end
            if ((state == EXECUTE) && settle_q) begin
                display_output <= result_sel;   // Shown together with complete
            end
        end
    end

endmodule

// File: verilog/digit_accumulator.sv
`timescale 1ns/1ps

module digit_accumulator
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  logic               load,            // Raw keystroke for this operand
    input  logic               clear,           // Zero the operand
    input  logic [DIGIT_W-1:0] digit,           // Key code, 0 to 15
    output logic [WORD_W-1:0]  value            // Operand so far
);

    logic              digit_ok;                // Decimal key only
    logic [WORD_W-1:0] times_ten;               // value * 8 + value * 2

    assign digit_ok  = (digit <= DIGIT_MAX);    // Keys 10 to 15 dropped
    assign times_ten = (value << 3) + (value << 1);     // Wraps at 2^16

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;                        // Clear wins over a key
        end else if (load && digit_ok) begin
            value <= times_ten + WORD_W'(digit);    // Shift in one decimal place
        end
    end

endmodule

// File: verilog/step_counter.sv
`timescale 1ns/1ps

module step_counter
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    exec_if.counter timing
);

    logic [STEP_W-1:0] count;                   // Steps remaining minus one
    logic              running;                 // Operation in progress

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            count   <= '0;
            running <= 1'b0;
        end else if (timing.start) begin
            count   <= timing.step_len - 1'b1;  // First index is len - 1
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;                // Idle after the last step
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign timing.step_idx = count;
    assign timing.last     = running && (count == '0);   // High during final step

endmodule

// File: verilog/nibble_add_sub.sv
`timescale 1ns/1ps

module nibble_add_sub
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    exec_if.adder alu
);

    logic              busy;                    // Steps still to run
    logic              carry;                   // Carry into current nibble
    logic [WORD_W-1:0] b_q;                     // Operand b, inverted for sub
    logic [1:0]        nib_sel;                 // Nibble of this step
    logic [3:0]        a_nib;
    logic [3:0]        b_nib;
    logic [3:0]        s_nib;                   // Nibble sum
    logic              carry_out;               // Into the next nibble

    // Index counts down while the nibbles go from low to high
    assign nib_sel = 2'(ADD_STEPS - 1 - alu.step_idx);

    assign a_nib = alu.operand_a[{nib_sel, 2'b00} +: 4];
    assign b_nib = b_q[{nib_sel, 2'b00} +: 4];

    always_comb begin
        {carry_out, s_nib} = {1'b0, a_nib} + {1'b0, b_nib} + {4'b0000, carry};
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            carry <= 1'b0;
        end else if (alu.start) begin
            busy  <= 1'b1;
            carry <= alu.sub;                   // Plus one for two's complement
        end else if (busy) begin
            carry <= carry_out;
            if (alu.step_idx == '0) begin
                busy <= 1'b0;                   // Top nibble done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alu.start) begin
            b_q <= alu.sub ? ~alu.operand_b : alu.operand_b;
        end else if (busy) begin
            alu.sum_result[{nib_sel, 2'b00} +: 4] <= s_nib;   // One nibble per step
        end
    end

endmodule

// File: verilog/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic clk,
    input  logic nRST,
    exec_if.mult mul
);

    logic [WORD_W-1:0] mcand;                   // Multiplicand, shifts left
    logic [WORD_W-1:0] mplier;                  // Multiplier, shifts right
    logic [WORD_W-1:0] acc;                     // Low half of partial product
    logic              add_now;                 // Current multiplier bit

    assign add_now = mplier[0];

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            mcand  <= '0;
            mplier <= '0;                       // Zero multiplier means idle
            acc    <= '0;
        end else if (mul.start) begin
            mcand  <= mul.operand_a;
            mplier <= mul.operand_b;
            acc    <= '0;
        end else if (mplier != '0) begin
            if (add_now) begin
                acc <= acc + mcand;             // Bits above 15 fall off
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;              // At most sixteen steps
        end
    end

    assign mul.mul_result = acc;

endmodule

// File: verilog/calc_top.sv
`timescale 1ns/1ps

module calc_top
    import calc_pkg::*;
(
    input  logic               clk,
    input  logic               nRST,
    input  logic               read_input,      // Keystroke strobe
    input  logic [DIGIT_W-1:0] keypad_input,    // Key code
    input  logic [2:0]         operator_input,  // One-hot operator
    input  logic               equal_input,     // Equal key
    output logic               complete,        // Result ready pulse
    output logic [WORD_W-1:0]  display_output   // Result register
);

    logic load_a;                               // Keystroke to first operand
    logic load_b;                               // Keystroke to second operand
    logic clear_ops;                            // Both operands to zero

    exec_if exec_bus ();

    calc_control ctrl (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .load_a         (load_a),
        .load_b         (load_b),
        .clear_ops      (clear_ops),
        .exec           (exec_bus.ctrl),
        .complete       (complete),
        .display_output (display_output)
    );

    digit_accumulator operand_a_reg (
        .clk   (clk),
        .nRST  (nRST),
        .load  (load_a),
        .clear (clear_ops),
        .digit (keypad_input),
        .value (exec_bus.operand_a)
    );

    digit_accumulator operand_b_reg (
        .clk   (clk),
        .nRST  (nRST),
        .load  (load_b),
        .clear (clear_ops),
        .digit (keypad_input),
        .value (exec_bus.operand_b)
    );

    step_counter counter (
        .clk    (clk),
        .nRST   (nRST),
        .timing (exec_bus.counter)
    );

    nibble_add_sub adder (
        .clk  (clk),
        .nRST (nRST),
        .alu  (exec_bus.adder)
    );

    shift_add_multiplier multiplier (
        .clk  (clk),
        .nRST (nRST),
        .mul  (exec_bus.mult)
    );

endmodule

// File: tb/calc_assertions.sv
`timescale 1ns/1ps

module calc_assertions
    import calc_pkg::*;
(
    input logic        clk,
    input logic        nRST,
    input calc_state_t state,                       // Controller FSM state
    input logic        complete,
    input logic        start,                       // Launch pulse to the units
    input logic        last,                        // Final step from the counter
    input logic        load_a,
    input logic        load_b
);

    // Done pulse is a single cycle
    complete_one_cycle: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |=> !complete
    ) else $error("complete stayed high for more than one cycle");

    start_in_launch: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> (state == LAUNCH)
    ) else $error("start pulsed outside LAUNCH");

    // Exit needs last one cycle earlier, the settle cycle
    execute_until_last: assert property (
        @(posedge clk) disable iff (!nRST)
        ((state == EXECUTE) && !$past(last)) |=> (state == EXECUTE)
    ) else $error("state left EXECUTE before last");

    load_in_entry: assert property (
        @(posedge clk) disable iff (!nRST)
        (load_a || load_b) |-> ((state == GET_FIRST) || (state == GET_SECOND))
    ) else $error("operand load outside the entry states");

endmodule

bind calc_control calc_assertions control_checks (
    .clk      (clk),
    .nRST     (nRST),
    .state    (state),
    .complete (complete),
    .start    (exec.start),
    .last     (exec.last),
    .load_a   (load_a),
    .load_b   (load_b)
);

// File: tb/calc_tb.sv
`timescale 1ns/1ps

module calc_tb
    import calc_pkg::*;
();

    localparam int CLK_PERIOD  = 8;                 // ns
    localparam int NUM_RANDOM  = 40;                // Plain random calculations
    localparam int NUM_NEG_SUB = 8;                 // Subtractions below zero
    localparam int NUM_JUNK    = 8;                 // Entry mixed with bad keys
    localparam int NUM_INJECT  = 8;                 // Keys pressed while busy
    localparam int NUM_RESET   = 4;                 // Each followed by a full calc
    localparam int NUM_TRANS   = NUM_RANDOM + NUM_NEG_SUB + NUM_JUNK + NUM_INJECT
                                 + 2 * NUM_RESET;
    localparam int DONE_LIMIT  = 100;               // Cycles allowed from equal to complete

    logic               clk = 1'b0;
    logic               nRST;
    logic               read_input;
    logic [DIGIT_W-1:0] keypad_input;
    logic [2:0]         operator_input;
    logic               equal_input;
    logic               complete;
    logic [WORD_W-1:0]  display_output;

    integer seed = 59012;                           // Fixed stimulus seed

    calc_top UUT (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .keypad_input   (keypad_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;        // 0 to n - 1
    endfunction

    function automatic logic [2:0] random_operator();
        case (rand_below(3))
            0:       return OP_ADD;
            1:       return OP_SUB;
            default: return OP_MUL;
        endcase
    endfunction

    function automatic logic [2:0] junk_operator();
        logic [2:0] code;
        code = 3'(rand_below(8));
        if ((code == OP_ADD) || (code == OP_SUB) || (code == OP_MUL)) begin
            code = 3'b111;                          // Never a valid key
        end
        return code;
    endfunction

    // Reference results modulo 2^16
    function automatic logic [WORD_W-1:0] model_result(input logic [2:0] op,
                                                       input logic [WORD_W-1:0] a,
                                                       input logic [WORD_W-1:0] b);
        logic [2*WORD_W-1:0] product;
        product = 32'(a) * 32'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;                  // Two's complement wrap
            default: return product[WORD_W-1:0];    // Low half only
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_word(input logic [WORD_W-1:0] actual,
                              input logic [WORD_W-1:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0d got %0d", $time, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Word mismatch");
        end
    endtask

    task automatic check_pulse(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %b got %b", $time, what, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Pulse mismatch");
        end
    endtask

    task automatic idle_inputs();
        read_input     = 1'b0;
        keypad_input   = '0;
        operator_input = 3'b000;                    // Not one-hot so ignored
        equal_input    = 1'b0;
    endtask

    // Keys one digit at a time and returns the model value of the operand
    task automatic enter_operand(input int ndigits, input int first_min, input bit junk,
                                 output logic [WORD_W-1:0] value);
        int d;
        int i;
        value = '0;
        for (i = 0; i < ndigits; i++) begin
            if (junk && (rand_below(2) == 1)) begin
                @(negedge clk);
                read_input     = 1'b1;
                keypad_input   = 4'(10 + rand_below(6));    // Keys 10 to 15
                operator_input = junk_operator();
            end
            d = (i == 0) ? first_min + rand_below(10 - first_min) : rand_below(10);
            @(negedge clk);
            read_input     = 1'b1;
            keypad_input   = 4'(d);
            operator_input = junk ? junk_operator() : 3'b000;
            value          = value * 16'd10 + 16'(d);       // Times-ten rule
            if (rand_below(4) == 0) begin
                @(negedge clk);
                read_input = 1'b0;                  // Gap between keys
            end
        end
        @(negedge clk);
        idle_inputs();
    endtask

    task automatic wait_complete();
        int cycles;
        cycles = 0;
        while (!complete && (cycles < DONE_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        if (!complete) begin
            report_failure("No complete pulse arrived after the equal key");
        end
    endtask

    // One full calculation checked against the model
    task automatic run_calc(input logic [2:0] op, input int na, input int nb,
                            input int b_min, input bit junk, input bit inject);
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        int i;
        enter_operand(na, 0, junk, a);
        @(negedge clk);
        operator_input = op;                        // Ends first operand
        @(negedge clk);
        operator_input = junk ? junk_operator() : 3'b000;
        enter_operand(nb, b_min, junk, b);
        @(negedge clk);
        equal_input = 1'b1;
        if (inject) begin
            for (i = 0; i < 3; i++) begin           // LAUNCH and early EXECUTE
                @(negedge clk);
                read_input     = 1'b1;
                keypad_input   = 4'(rand_below(16));
                operator_input = 3'(rand_below(8));
                equal_input    = 1'(rand_below(2));
            end
        end
        @(negedge clk);
        idle_inputs();
        wait_complete();
        check_word(display_output, model_result(op, a, b), "display_output");
        @(negedge clk);
        check_pulse(complete, 1'b0, "complete one cycle later");
    endtask

    // Reset lands in LAUNCH or EXECUTE and is held past the normal result time
    task automatic reset_during_calc();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        int i;
        enter_operand(1 + rand_below(5), 0, 1'b0, a);
        @(negedge clk);
        operator_input = random_operator();
        @(negedge clk);
        operator_input = 3'b000;
        enter_operand(1 + rand_below(5), 0, 1'b0, b);
        @(negedge clk);
        equal_input = 1'b1;
        @(negedge clk);
        equal_input = 1'b0;
        repeat (rand_below(4)) @(negedge clk);
        nRST = 1'b0;
        for (i = 0; i < MUL_STEPS + 4; i++) begin   // Longer than any operation
            @(negedge clk);
            check_pulse(complete, 1'b0, "complete during reset");
        end
        nRST = 1'b1;
        for (i = 0; i < 2 * MUL_STEPS; i++) begin
            @(negedge clk);
            check_pulse(complete, 1'b0, "complete after mid-run reset");
        end
    endtask

    initial begin
        int n;
        nRST = 1'b0;
        idle_inputs();
        repeat (2) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        check_word(display_output, '0, "display_output after reset");
        check_pulse(complete, 1'b0, "complete after reset");

        for (n = 0; n < NUM_RANDOM; n++) begin
            run_calc(random_operator(), 1 + rand_below(5), 1 + rand_below(5), 0, 1'b0, 1'b0);
        end
        for (n = 0; n < NUM_NEG_SUB; n++) begin     // b of 3 or 4 digits beats a <= 99
            run_calc(OP_SUB, 1 + rand_below(2), 3 + rand_below(2), 1, 1'b0, 1'b0);
        end
        for (n = 0; n < NUM_JUNK; n++) begin
            run_calc(random_operator(), 1 + rand_below(5), 1 + rand_below(5), 0, 1'b1, 1'b0);
        end
        for (n = 0; n < NUM_INJECT; n++) begin
            run_calc(random_operator(), 1 + rand_below(5), 1 + rand_below(5), 0, 1'b0, 1'b1);
        end
        for (n = 0; n < NUM_RESET; n++) begin
            reset_during_calc();
            run_calc(random_operator(), 1 + rand_below(5), 1 + rand_below(5), 0, 1'b0, 1'b0);
        end

        $display("Testbench passed");
        $finish;
    end

    // Watchdog allows 200 cycles per transaction
    initial begin
        #(NUM_TRANS * 200 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", NUM_TRANS * 200);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: src.f
verilog/calc_pkg.sv
verilog/exec_if.sv
verilog/calc_control.sv
verilog/digit_accumulator.sv
verilog/step_counter.sv
verilog/nibble_add_sub.sv
verilog/shift_add_multiplier.sv
verilog/calc_top.sv
tb/calc_assertions.sv
tb/calc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the calculator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module calc_tb -f src.f -o calc_sim \
    && { ./obj_dir/calc_sim > "$LOG" 2>&1 || true; } \
    && cat "$LOG" \
    && grep -q "^Testbench passed$" "$LOG" \
    && echo "Simulation PASS" \
    || { echo "Simulation FAIL"; exit 1; }
